// ==== logic/deser_pkg.sv ====
// lane count, word width, slip and history widths, bit-order and endian constants
// shared vector types for the deserializer
package deser_pkg;

	//--------------------------------------------------------------------------
	// sizes
	//--------------------------------------------------------------------------
	localparam int CHANNEL_NUM = 4;                 // serial lanes
	localparam int DESER_WIDTH = 6;                 // bits per lane word, 2 to 8
	localparam int SLIP_W      = 3;                 // offset 0 .. DESER_WIDTH-1
	localparam int HIST_W      = 2*DESER_WIDTH - 1; // newest word plus worst slip

	//--------------------------------------------------------------------------
	// ordering options
	//--------------------------------------------------------------------------
	// where the earliest received bit of a word lands
	typedef enum logic {
		FIRST_MSB, // earliest bit in the top position
		FIRST_LSB  // earliest bit in bit 0
	} first_bit_e;

	// where channel 0 lands in the packed output
	typedef enum logic {
		END_LITTLE, // ch0 in the lowest slice
		END_BIG     // ch0 in the highest slice
	} endian_e;

	localparam first_bit_e SER_FIRST_BIT = FIRST_LSB;
	localparam endian_e    END_STYLE     = END_LITTLE;

	//--------------------------------------------------------------------------
	// vector types
	//--------------------------------------------------------------------------
	typedef logic [DESER_WIDTH-1:0]             lane_word_t;  // one lane word
	typedef logic [CHANNEL_NUM-1:0]             chan_vec_t;   // one bit per lane
	typedef logic [SLIP_W-1:0]                  slip_t;       // slip offset
	typedef logic [CHANNEL_NUM*DESER_WIDTH-1:0] deser_word_t; // all lanes packed

endpackage

// ==== logic/deser_lane.sv ====
// one serial lane: bit history, bitslip offset counter, word window
// and first-bit ordering of the recovered lane word
module deser_lane (
	input  logic                  clk_io,     // serial bit clock
	input  logic                  rst_n,      // sync reset, active low
	input  logic                  serial_bit, // one bit per rising edge
	input  logic                  slip,       // one-cycle bitslip pulse
	output deser_pkg::lane_word_t lane_word   // current word, ordered
);

	// bits sampled on earlier edges, newest in bit 0
	logic [deser_pkg::HIST_W-2:0] hist_q;
	// full history seen by the window, bit 0 is this edge's input
	logic [deser_pkg::HIST_W-1:0] hist;
	// history moved down by the slip offset
	logic [deser_pkg::HIST_W-1:0] hist_shift;
	// word boundary, counts slips
	deser_pkg::slip_t             offset_q;
	// raw window, earliest bit at the top
	deser_pkg::lane_word_t        window;

	//--------------------------------------------------------------------------
	// bit history
	//--------------------------------------------------------------------------
	// the current input joins combinationally so a strobe on this edge
	// already sees the bit being sampled now
	assign hist = {hist_q, serial_bit};

	always_ff @(posedge clk_io) begin
		if (!rst_n) begin
			hist_q <= '0;
		end else begin
			hist_q <= hist[deser_pkg::HIST_W-2:0]; // oldest bit falls off
		end
	end

	//--------------------------------------------------------------------------
	// slip offset
	//--------------------------------------------------------------------------
	// each slip moves the boundary one bit earlier (older bits)
	// after DESER_WIDTH slips the word lines up where it started
	always_ff @(posedge clk_io) begin
		if (!rst_n) begin
			offset_q <= '0;
		end else if (slip) begin
			if (offset_q == deser_pkg::slip_t'(deser_pkg::DESER_WIDTH - 1)) begin
				offset_q <= '0;                               // wrap
			end else begin
				offset_q <= offset_q + deser_pkg::slip_t'(1); // one bit back
			end
		end
	end

	//--------------------------------------------------------------------------
	// window extraction
	//--------------------------------------------------------------------------
	// offset 0 -> newest DESER_WIDTH bits
	// offset n -> same span, n bits further into the past
	// top offset reaches hist[HIST_W-1], the oldest bit kept
	assign hist_shift = hist >> offset_q;
	assign window     = hist_shift[deser_pkg::DESER_WIDTH-1:0];

	//--------------------------------------------------------------------------
	// bit ordering
	//--------------------------------------------------------------------------
	// window[DESER_WIDTH-1] holds the earliest bit of the word,
	// window[0] the latest
	generate
		if (deser_pkg::SER_FIRST_BIT == deser_pkg::FIRST_LSB) begin : g_lsb_first
			// earliest bit goes to bit 0, so flip the window end for end
			always_comb begin
				for (int b = 0; b < deser_pkg::DESER_WIDTH; b++) begin
					lane_word[b] = window[deser_pkg::DESER_WIDTH-1-b];
				end
			end
		end else begin : g_msb_first
			// earliest bit already sits at the top
			assign lane_word = window;
		end
	endgenerate

	// e.g. 6 bits, offset 0, bits arriving t0..t5 = 0 1 0 1 0 1
	//   window    = {t0,t1,t2,t3,t4,t5} = 6'b010101
	//   LSB first -> lane_word = {t5,t4,t3,t2,t1,t0} = 6'b101010
	//   MSB first -> lane_word = 6'b010101

endmodule

// ==== logic/deser_word_out.sv ====
// strobe-gated output register: packs the lane words by channel endianness
// and raises a one-cycle data_valid per new word
module deser_word_out (
	input  logic                   clk_io,                              // serial bit clock
	input  logic                   rst_n,                               // sync reset, active low
	input  logic                   strobe,                              // closes a word
	input  deser_pkg::lane_word_t  lane_words [deser_pkg::CHANNEL_NUM], // per lane
	output deser_pkg::deser_word_t data_recover,                        // packed word
	output logic                   data_valid                           // new-word pulse
);

	// lane words placed in their output slices, ahead of the register
	deser_pkg::deser_word_t packed_word;

	//--------------------------------------------------------------------------
	// channel packing
	//--------------------------------------------------------------------------
	// LITTLE : {ch3, ch2, ch1, ch0}, ch0 in the low slice
	// BIG    : {ch0, ch1, ch2, ch3}, ch0 in the high slice
	// bit order inside each slice is untouched here, the lane already did it
	always_comb begin
		packed_word = '0;
		for (int ch = 0; ch < deser_pkg::CHANNEL_NUM; ch++) begin
			if (deser_pkg::END_STYLE == deser_pkg::END_LITTLE) begin
				packed_word[ch*deser_pkg::DESER_WIDTH +: deser_pkg::DESER_WIDTH] =
					lane_words[ch];
			end else begin
				packed_word[ch*deser_pkg::DESER_WIDTH +: deser_pkg::DESER_WIDTH] =
					lane_words[deser_pkg::CHANNEL_NUM-1-ch]; // mirrored
			end
		end
	end

	//--------------------------------------------------------------------------
	// output register
	//--------------------------------------------------------------------------
	// strobe on edge k loads the words as they stand at edge k,
	// valid follows one cycle later and lasts one cycle
	always_ff @(posedge clk_io) begin
		if (!rst_n) begin
			data_recover <= '0;
			data_valid   <= 1'b0;
		end else begin
			data_valid <= strobe; // fixed one-cycle latency
			if (strobe) begin
				data_recover <= packed_word; // overwrite, no back-pressure
			end
		end
	end

	// between strobes data_recover just holds, valid stays low

endmodule

// ==== logic/deser_data.sv ====
// top level of the multi-channel deserializer:
// one lane per serial input and the shared output stage
module deser_data (
	input  logic                   clk_io,       // serial bit clock
	input  logic                   rst_n,        // sync reset, active low
	input  deser_pkg::chan_vec_t   data_in,      // one serial bit per lane
	input  logic                   serdesstrobe, // word boundary pulse
	input  deser_pkg::chan_vec_t   bitslip,      // per-lane slip pulse
	output deser_pkg::deser_word_t data_recover, // packed recovered word
	output logic                   data_valid    // one cycle after each strobe
);

	// combinational word of each lane, into the output stage
	deser_pkg::lane_word_t lane_word [deser_pkg::CHANNEL_NUM];

	//--------------------------------------------------------------------------
	// lanes
	//--------------------------------------------------------------------------
	// lanes shift every cycle and never see the strobe,
	// only the output stage decides when a word is taken
	generate
		for (genvar i = 0; i < deser_pkg::CHANNEL_NUM; i++) begin : lane
			deser_lane u_lane (
				.clk_io     (clk_io),
				.rst_n      (rst_n),
				.serial_bit (data_in[i]),
				.slip       (bitslip[i]), // own slip, lanes align independently
				.lane_word  (lane_word[i])
			);
		end
	endgenerate

	//--------------------------------------------------------------------------
	// output stage
	//--------------------------------------------------------------------------
	deser_word_out word_out (
		.clk_io       (clk_io),
		.rst_n        (rst_n),
		.strobe       (serdesstrobe),
		.lane_words   (lane_word),
		.data_recover (data_recover),
		.data_valid   (data_valid)
	);

endmodule

// ==== tests/deser_data_properties.sv ====
// bound assertions on the deserializer top level:
// strobe-to-valid latency, reset state, word hold between strobes
module deser_data_properties (
	input logic                   clk_io,       // serial bit clock
	input logic                   rst_n,        // sync reset, active low
	input logic                   serdesstrobe, // word boundary pulse
	input logic                   data_valid,   // new-word pulse
	input deser_pkg::deser_word_t data_recover  // packed word
);

	// low only on the first edge, $past has no history there
	logic past_ok = 1'b0;

	always @(posedge clk_io) past_ok <= 1'b1;

	//--------------------------------------------------------------------------
	// latency
	//--------------------------------------------------------------------------
	// valid is the strobe delayed by one edge, whenever that edge was out of reset
	a_valid_latency : assert property (@(posedge clk_io)
		(past_ok && $past(rst_n)) |-> (data_valid == $past(serdesstrobe)))
		else $error("data_valid is not serdesstrobe delayed by one cycle");

	//--------------------------------------------------------------------------
	// reset state
	//--------------------------------------------------------------------------
	// a reset edge leaves valid low and the word cleared
	a_reset_state : assert property (@(posedge clk_io)
		(past_ok && !$past(rst_n)) |-> (!data_valid && data_recover == '0))
		else $error("outputs not cleared after a reset cycle");

	//--------------------------------------------------------------------------
	// hold
	//--------------------------------------------------------------------------
	// no strobe, no new word
	a_word_hold : assert property (@(posedge clk_io)
		(past_ok && $past(rst_n) && !$past(serdesstrobe)) |-> $stable(data_recover))
		else $error("data_recover changed without a strobe");

endmodule

bind deser_data deser_data_properties props (
	.clk_io       (clk_io),
	.rst_n        (rst_n),
	.serdesstrobe (serdesstrobe),
	.data_valid   (data_valid),
	.data_recover (data_recover)
);

// ==== tests/deser_data_tb.sv ====
// testbench for the multi-channel deserializer: clock, reset, random serial stimulus,
// bitslip scenarios, reference word model, comparison process and closing report
module deser_data_tb;

	localparam int RESET_CYCLES  = 8;                          // rst_n low for this many edges
	localparam int VALID_TIMEOUT = 4 * deser_pkg::DESER_WIDTH; // max cycles between words
	localparam int DRAIN_TIMEOUT = 50;                         // end of run, cycles
	localparam int WAIT_DONE     = 0;                          // wait_valid results
	localparam int WAIT_VALID    = 1;
	localparam int WAIT_TIMEOUT  = 2;

	// DUT ports
	logic                   clk_io = 1'b0;
	logic                   rst_n;
	deser_pkg::chan_vec_t   data_in;
	logic                   serdesstrobe;
	deser_pkg::chan_vec_t   bitslip;
	deser_pkg::deser_word_t data_recover;
	logic                   data_valid;

	// reference state
	deser_pkg::chan_vec_t   bit_log [$];                       // every driven data_in, oldest first
	int                     ref_offset [deser_pkg::CHANNEL_NUM]; // slip offset per lane
	int                     slips_due [deser_pkg::CHANNEL_NUM];  // pulses still to send
	deser_pkg::deser_word_t exp_word_q [$];                    // one entry per strobe
	int                     exp_cyc_q [$];                     // cycle the valid is due
	string                  exp_tag_q [$];                     // phase name for messages
	string                  phase;
	deser_pkg::deser_word_t held_word;                         // last word seen with valid

	int cyc        = 0; // clock edge counter
	int n_checks   = 0;
	int n_errors   = 0;
	int n_timeouts = 0;
	bit stim_done  = 1'b0;
	bit cmp_done   = 1'b0;

	deser_data dut (
		.clk_io       (clk_io),
		.rst_n        (rst_n),
		.data_in      (data_in),
		.serdesstrobe (serdesstrobe),
		.bitslip      (bitslip),
		.data_recover (data_recover),
		.data_valid   (data_valid)
	);

	initial begin
		forever #10 clk_io = ~clk_io;
	end

	always @(posedge clk_io) cyc <= cyc + 1;

	//--------------------------------------------------------------------------
	// checking helpers
	//--------------------------------------------------------------------------
	task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
			input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("** Error @ %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	// one lane word from the bit log: window ends offs bits before the newest bit
	function automatic deser_pkg::lane_word_t lane_ref(input int ch, input int offs);
		deser_pkg::lane_word_t w;
		int                    newest;
		int                    idx;
		newest = bit_log.size() - 1 - offs;
		for (int b = 0; b < deser_pkg::DESER_WIDTH; b++) begin
			if (deser_pkg::SER_FIRST_BIT == deser_pkg::FIRST_LSB) begin
				idx = newest - (deser_pkg::DESER_WIDTH - 1) + b; // earliest -> bit 0
			end else begin
				idx = newest - b;                                // earliest -> top bit
			end
			w[b] = (idx >= 0) ? bit_log[idx][ch] : 1'b0; // zeros before reset release
		end
		return w;
	endfunction

	// packed word expected for a strobe on the coming edge
	function automatic deser_pkg::deser_word_t word_ref();
		deser_pkg::deser_word_t w;
		int                     base;
		w = '0;
		for (int ch = 0; ch < deser_pkg::CHANNEL_NUM; ch++) begin
			if (deser_pkg::END_STYLE == deser_pkg::END_LITTLE) begin
				base = ch * deser_pkg::DESER_WIDTH;                           // ch0 low
			end else begin
				base = (deser_pkg::CHANNEL_NUM - 1 - ch) * deser_pkg::DESER_WIDTH; // ch0 high
			end
			w[base +: deser_pkg::DESER_WIDTH] = lane_ref(ch, ref_offset[ch]);
		end
		return w;
	endfunction

	//--------------------------------------------------------------------------
	// stimulus
	//--------------------------------------------------------------------------
	// drive one cycle right now, called on a falling edge
	task automatic apply_cycle(input logic strobe);
		deser_pkg::chan_vec_t bits;
		deser_pkg::chan_vec_t slips;
		bits  = deser_pkg::chan_vec_t'($urandom);
		slips = '0;
		for (int ch = 0; ch < deser_pkg::CHANNEL_NUM; ch++) begin
			if (slips_due[ch] > 0) begin
				slips[ch] = 1'b1; // one pulse per cycle
				slips_due[ch]--;
			end
		end
		data_in      = bits;
		serdesstrobe = strobe;
		bitslip      = slips;
		bit_log.push_back(bits);
		if (strobe) begin
			exp_word_q.push_back(word_ref());
			exp_cyc_q.push_back(cyc + 1); // valid seen after the next edge
			exp_tag_q.push_back(phase);
		end
		// a slip on the strobe edge only counts from the next strobe
		for (int ch = 0; ch < deser_pkg::CHANNEL_NUM; ch++) begin
			if (slips[ch]) begin
				ref_offset[ch] = (ref_offset[ch] + 1) % deser_pkg::DESER_WIDTH;
			end
		end
	endtask

	task automatic next_cycle(input logic strobe);
		@(negedge clk_io);
		apply_cycle(strobe);
	endtask

	// frames of DESER_WIDTH cycles, strobe on the last one
	task automatic run_frames(input int n, input string tag);
		phase = tag;
		repeat (n) begin
			for (int i = 0; i < deser_pkg::DESER_WIDTH; i++) begin
				next_cycle(i == deser_pkg::DESER_WIDTH - 1);
			end
		end
	endtask

	//--------------------------------------------------------------------------
	// comparison
	//--------------------------------------------------------------------------
	// hold and idle checks on every cycle without valid
	task automatic wait_valid(output int status);
		int idle;
		idle   = 0;
		status = WAIT_TIMEOUT;
		while (idle < VALID_TIMEOUT) begin
			if (stim_done && exp_word_q.size() == 0) begin
				status = WAIT_DONE;
				break;
			end
			@(negedge clk_io);
			if (data_valid === 1'b1) begin
				status = WAIT_VALID;
				break;
			end
			idle++;
			check_value(64'(data_valid), 64'(0), "data_valid between strobes");
			check_value(64'(data_recover), 64'(held_word), "data_recover hold");
		end
	endtask

	initial begin : compare_words
		deser_pkg::deser_word_t exp_word;
		int                     exp_cyc;
		string                  tag;
		int                     status;
		bit                     running;
		int                     base;
		// outputs of every reset edge
		repeat (RESET_CYCLES) begin
			@(negedge clk_io);
			check_value(64'(data_valid), 64'(0), "data_valid in reset");
			check_value(64'(data_recover), 64'(0), "data_recover in reset");
		end
		held_word = '0; // still zero until the first strobe
		running   = 1'b1;
		while (running) begin
			wait_valid(status);
			if (status == WAIT_VALID) begin
				if (exp_word_q.size() == 0) begin
					check_value(64'(data_valid), 64'(0), "data_valid with no strobe");
				end else begin
					exp_word = exp_word_q.pop_front();
					exp_cyc  = exp_cyc_q.pop_front();
					tag      = exp_tag_q.pop_front();
					check_value(64'(cyc), 64'(exp_cyc), {tag, ": valid one cycle after strobe"});
					for (int s = 0; s < deser_pkg::CHANNEL_NUM; s++) begin
						base = s * deser_pkg::DESER_WIDTH; // slices low to high
						check_value(64'(data_recover[base +: deser_pkg::DESER_WIDTH]),
							64'(exp_word[base +: deser_pkg::DESER_WIDTH]),
							$sformatf("%s: slice %0d", tag, s));
					end
				end
				held_word = data_recover;
			end else if (status == WAIT_TIMEOUT) begin
				n_timeouts++;
				$display("timeout: no data_valid within %0d cycles at time %0t",
					VALID_TIMEOUT, $time);
				running = 1'b0;
			end else begin
				running = 1'b0; // stimulus over, nothing outstanding
			end
		end
		cmp_done = 1'b1;
	end

	//--------------------------------------------------------------------------
	// main sequence
	//--------------------------------------------------------------------------
	initial begin : main_sequence
		int wait_cnt;
		void'($urandom(48));
		rst_n        = 1'b0;
		data_in      = '1;   // inputs busy through reset
		serdesstrobe = 1'b1; // a strobe in reset must not load a word
		bitslip      = '1;   // nor move any offset
		phase        = "reset";
		for (int ch = 0; ch < deser_pkg::CHANNEL_NUM; ch++) begin
			ref_offset[ch] = 0;
			slips_due[ch]  = 0;
		end

		repeat (RESET_CYCLES) @(negedge clk_io);
		rst_n = 1'b1;
		apply_cycle(1'b0); // first bit after release enters the log

		run_frames(8, "aligned");

		slips_due[1] = 1; // boundary one bit earlier on lane 1
		run_frames(6, "single slip lane 1");

		slips_due[2] = deser_pkg::DESER_WIDTH; // full turn, back to offset 0
		run_frames(6, "wrap lane 2");

		slips_due[0] = 3; // lanes slipped by different counts
		slips_due[1] = 2;
		slips_due[3] = 5;
		run_frames(8, "mixed slips");

		next_cycle(1'b0);
		next_cycle(1'b0);
		@(posedge clk_io);
		stim_done = 1'b1;

		wait_cnt = 0;
		while (!cmp_done && wait_cnt < DRAIN_TIMEOUT) begin
			@(posedge clk_io);
			wait_cnt++;
		end
		if (!cmp_done) begin
			n_timeouts++;
			$display("timeout: comparison process did not finish after the stimulus");
		end

		$display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
		if (n_errors == 0 && n_timeouts == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
logic/deser_pkg.sv
logic/deser_lane.sv
logic/deser_word_out.sv
logic/deser_data.sv
tests/deser_data_properties.sv
tests/deser_data_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the deserializer testbench with Verilator and run it
# exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

TOP=deser_data_tb
OBJ_DIR=obj_dir
LOG=sim.log

echo "compiling $TOP"
verilator --binary --timing --assert \
	--top-module "$TOP" \
	-Mdir "$OBJ_DIR" \
	-o "$TOP" \
	-f sim.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "compile failed with status $status"
	exit 1
fi

echo "running $TOP"
"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the testbench prints its pass line on a line of its own
if grep -q '^>>> PASS$' "$LOG"; then
	echo "result: passed"
	exit 0
else
	echo "result: failed, see $LOG"
	exit 1
fi
